//--- design/t08_mmio_pkg.sv
package t08_mmio_pkg;

    // bus widths
    localparam int DATA_W = 32;                 // data words and addresses
    localparam int SEL_W  = DATA_W / 8;         // one wb select bit per byte lane

    // address map
    localparam logic [DATA_W-1:0] SPI_ADDR_CMD   = 32'd121212;  // display command + param count
    localparam logic [DATA_W-1:0] SPI_ADDR_PARAM = 32'd333333;  // display parameter word
    localparam logic [DATA_W-1:0] I2C_ADDR_XY    = 32'd923923;  // touch x/y register

    // data memory window, every address below this is memory
    localparam int MEM_WORDS  = 2048;
    localparam int MEM_ADDR_W = $clog2(MEM_WORDS);  // word index bits

    // marker words
    localparam logic [DATA_W-1:0] MEM_BUSY_WORD   = 32'hDEAD_BEEF;  // read while mem busy
    localparam logic [DATA_W-1:0] MEM_POISON_WORD = 32'hBAD1_BAD1;  // never handed to the cpu

    // timing, all in clk cycles
    localparam int MEM_LATENCY         = 3;     // busy window after a wb strobe
    localparam int SPI_DRAIN_CYCLES    = 4;     // spi busy tail after last frame word
    localparam int TOUCH_SETTLE_CYCLES = 5;     // done low after a new coordinate

    // spi command word layout
    localparam int SPI_COUNT_LSB = 8;           // param count sits in bits 11:8
    localparam int SPI_COUNT_W   = 4;

    // counter widths, sized to hold the full load value
    localparam int MEM_CNT_W   = $clog2(MEM_LATENCY + 1);
    localparam int SPI_DRAIN_W = $clog2(SPI_DRAIN_CYCLES + 1);
    localparam int TOUCH_CNT_W = $clog2(TOUCH_SETTLE_CYCLES + 1);

endpackage

//--- design/t08_mmio.sv
`timescale 1ns/1ns

module t08_mmio (
    input  logic                             clk,
    input  logic                             nRst,
    // memory handler side
    input  logic                             read_i,        // read level, target from address
    input  logic                             write_i,       // write level
    input  logic                             wb_read_i,     // one cycle memory read strobe
    input  logic                             wb_write_i,    // one cycle memory write strobe
    input  logic [t08_mmio_pkg::DATA_W-1:0]  address_i,
    input  logic [t08_mmio_pkg::DATA_W-1:0]  mh_data_i,     // write word
    // touch side
    input  logic [t08_mmio_pkg::DATA_W-1:0]  i2c_xy_i,
    input  logic                             i2c_done_i,
    // spi side
    input  logic                             spi_busy_i,
    // memory side
    input  logic [t08_mmio_pkg::DATA_W-1:0]  mem_data_i,    // registered read word
    input  logic                             mem_busy_i,
    // back to memory handler
    output logic [t08_mmio_pkg::DATA_W-1:0]  mh_data_o,
    output logic                             mmio_busy_o,
    output logic                             i2c_done_o,
    output logic                             mmio_done_o,
    // spi command port
    output logic [t08_mmio_pkg::DATA_W-1:0]  spi_data_o,
    output logic                             spi_comm_enable_o,
    output logic                             spi_param_enable_o,
    // wb memory port
    output logic [t08_mmio_pkg::DATA_W-1:0]  mem_data_o,
    output logic [t08_mmio_pkg::DATA_W-1:0]  mem_address_o,
    output logic [t08_mmio_pkg::SEL_W-1:0]   mem_select_o,
    output logic                             mem_write_o,
    output logic                             mem_read_o
);
    import t08_mmio_pkg::*;

    logic is_read;              // read only, write low
    logic is_write;             // write only, read low
    logic hit_mem;
    logic hit_spi_cmd;
    logic hit_spi_param;
    logic hit_i2c;
    logic busy_q1;              // busy one edge back
    logic busy_q2;              // busy two edges back

    // both levels high or both low is no request at all
    assign is_read  = read_i & ~write_i;
    assign is_write = write_i & ~read_i;

    // address decode
    assign hit_mem       = address_i < DATA_W'(MEM_WORDS);
    assign hit_spi_cmd   = address_i == SPI_ADDR_CMD;
    assign hit_spi_param = address_i == SPI_ADDR_PARAM;
    assign hit_i2c       = address_i == I2C_ADDR_XY;

    assign mmio_busy_o  = spi_busy_i | mem_busy_i | ~i2c_done_i;
    assign i2c_done_o   = i2c_done_i;
    assign mem_select_o = '1;               // full word lanes only
    assign mem_read_o   = wb_read_i;        // strobes go straight to memory
    assign mem_write_o  = wb_write_i;

    // busy history for done
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            busy_q1 <= 1'b0;
            busy_q2 <= 1'b0;
        end else begin
            busy_q1 <= mmio_busy_o;
            busy_q2 <= busy_q1;
        end
    end

    assign mmio_done_o = busy_q1 & busy_q2;  // busy held over both past edges

    // request routing, follows the current inputs
    always_comb begin
        mh_data_o          = '0;
        spi_data_o         = '0;
        spi_comm_enable_o  = 1'b0;
        spi_param_enable_o = 1'b0;
        mem_data_o         = '0;
        mem_address_o      = '0;

        if (is_read) begin
            if (hit_i2c) begin
                if (i2c_done_i) begin
                    mh_data_o = i2c_xy_i;           // coordinate only once settled
                end
            end else if (hit_mem) begin
                if (mem_busy_i) begin
                    mh_data_o = MEM_BUSY_WORD;
                end else begin
                    mem_address_o = address_i;
                    if (mem_data_i != MEM_POISON_WORD) begin
                        mh_data_o = mem_data_i;     // poison reads as zero
                    end
                end
            end
        end else if (is_write) begin
            if (hit_spi_cmd) begin
                if (!spi_busy_i) begin              // refused mid frame, cpu retries
                    spi_data_o        = mh_data_i;
                    spi_comm_enable_o = 1'b1;
                end
            end else if (hit_spi_param) begin
                spi_data_o         = mh_data_i;     // collector decides if it counts
                spi_param_enable_o = 1'b1;
            end else if (hit_mem) begin
                if (!mem_busy_i) begin
                    mem_data_o    = mh_data_i;
                    mem_address_o = address_i;
                end
            end
        end
    end

endmodule

//--- design/t08_data_sram.sv
`timescale 1ns/1ns

module t08_data_sram (
    input  logic                             clk,
    input  logic                             nRst,
    input  logic                             mem_read_i,     // wb read strobe
    input  logic                             mem_write_i,    // wb write strobe
    input  logic [t08_mmio_pkg::DATA_W-1:0]  mem_address_i,
    input  logic [t08_mmio_pkg::DATA_W-1:0]  mem_data_i,
    input  logic [t08_mmio_pkg::SEL_W-1:0]   mem_select_i,   // byte lane enables
    output logic [t08_mmio_pkg::DATA_W-1:0]  mem_data_o,     // read register
    output logic                             mem_busy_o
);
    import t08_mmio_pkg::*;

    logic [DATA_W-1:0]     mem [MEM_WORDS];
    logic [MEM_ADDR_W-1:0] word_addr;
    logic [MEM_ADDR_W-1:0] rd_addr;     // address of the read in flight
    logic                  rd_pending;
    logic [MEM_CNT_W-1:0]  busy_cnt;
    logic                  accept;

    assign word_addr  = mem_address_i[MEM_ADDR_W-1:0];
    assign mem_busy_o = busy_cnt != '0;
    assign accept     = (mem_read_i | mem_write_i) & ~mem_busy_o;  // strobes dropped while busy

    // storage, writes land at once
    always_ff @(posedge clk) begin
        if (accept && mem_write_i) begin
            for (int lane = 0; lane < SEL_W; lane++) begin
                if (mem_select_i[lane]) begin
                    mem[word_addr][lane*8 +: 8] <= mem_data_i[lane*8 +: 8];
                end
            end
        end
        if (accept && mem_read_i) begin
            rd_addr <= word_addr;           // decoder stops driving address once busy
        end
    end

    // busy window and read register
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            busy_cnt   <= '0;
            rd_pending <= 1'b0;
            mem_data_o <= '0;
        end else if (accept) begin
            busy_cnt   <= MEM_CNT_W'(MEM_LATENCY);   // busy from the next cycle
            rd_pending <= mem_read_i;
        end else if (mem_busy_o) begin
            busy_cnt <= busy_cnt - 1'b1;
            if (busy_cnt == MEM_CNT_W'(1) && rd_pending) begin
                mem_data_o <= mem[rd_addr];         // word ready as busy falls
                rd_pending <= 1'b0;
            end
        end
    end

endmodule

//--- design/t08_spi_cmd_collector.sv
`timescale 1ns/1ns

module t08_spi_cmd_collector (
    input  logic                             clk,
    input  logic                             nRst,
    input  logic [t08_mmio_pkg::DATA_W-1:0]  spi_data_i,
    input  logic                             spi_comm_enable_i,   // command word strobe
    input  logic                             spi_param_enable_i,  // parameter word strobe
    output logic                             spi_busy_o,
    output logic [t08_mmio_pkg::DATA_W-1:0]  spi_word_o,          // last accepted word
    output logic                             spi_word_valid_o,    // one cycle per word
    output logic                             spi_is_param_o
);
    import t08_mmio_pkg::*;

    logic [SPI_COUNT_W-1:0] cmd_count;      // count field of incoming command
    logic [SPI_COUNT_W-1:0] params_left;
    logic                   in_frame;       // still waiting on parameters
    logic [SPI_DRAIN_W-1:0] drain_cnt;
    logic                   take_cmd;
    logic                   take_param;

    assign cmd_count  = spi_data_i[SPI_COUNT_LSB +: SPI_COUNT_W];
    assign spi_busy_o = in_frame | (drain_cnt != '0);
    assign take_cmd   = spi_comm_enable_i & ~spi_busy_o;
    assign take_param = spi_param_enable_i & in_frame;   // stray params ignored

    // frame tracking
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            params_left <= '0;
            in_frame    <= 1'b0;
            drain_cnt   <= '0;
        end else if (take_cmd) begin
            params_left <= cmd_count;
            if (cmd_count == '0) begin
                drain_cnt <= SPI_DRAIN_W'(SPI_DRAIN_CYCLES);   // bare command, drain now
            end else begin
                in_frame <= 1'b1;
            end
        end else if (take_param) begin
            params_left <= params_left - 1'b1;
            if (params_left == SPI_COUNT_W'(1)) begin
                in_frame  <= 1'b0;                              // last param
                drain_cnt <= SPI_DRAIN_W'(SPI_DRAIN_CYCLES);
            end
        end else if (drain_cnt != '0) begin
            drain_cnt <= drain_cnt - 1'b1;
        end
    end

    // word output flags
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            spi_word_valid_o <= 1'b0;
            spi_is_param_o   <= 1'b0;
        end else begin
            spi_word_valid_o <= take_cmd | take_param;
            spi_is_param_o   <= take_param;
        end
    end

    // word itself, only moves on an accepted strobe
    always_ff @(posedge clk) begin
        if (take_cmd || take_param) begin
            spi_word_o <= spi_data_i;
        end
    end

endmodule

//--- design/t08_touch_latch.sv
`timescale 1ns/1ns

module t08_touch_latch (
    input  logic                             clk,
    input  logic                             nRst,
    input  logic [t08_mmio_pkg::DATA_W-1:0]  touch_xy_i,      // packed x/y from touch panel
    input  logic                             touch_strobe_i,  // new sample
    output logic [t08_mmio_pkg::DATA_W-1:0]  i2c_xy_o,
    output logic                             i2c_done_o
);
    import t08_mmio_pkg::*;

    logic [TOUCH_CNT_W-1:0] settle_cnt;     // cycles left before sample counts

    assign i2c_done_o = settle_cnt == '0;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            settle_cnt <= '0;               // done high out of reset
            i2c_xy_o   <= '0;
        end else if (touch_strobe_i) begin
            i2c_xy_o   <= touch_xy_i;
            settle_cnt <= TOUCH_CNT_W'(TOUCH_SETTLE_CYCLES);  // restart on every strobe
        end else if (!i2c_done_o) begin
            settle_cnt <= settle_cnt - 1'b1;
        end
    end

endmodule

//--- design/t08_mmio_top.sv
`timescale 1ns/1ns

module t08_mmio_top (
    input  logic                             clk,
    input  logic                             nRst,
    // memory handler
    input  logic                             read_i,
    input  logic                             write_i,
    input  logic                             wb_read_i,
    input  logic                             wb_write_i,
    input  logic [t08_mmio_pkg::DATA_W-1:0]  address_i,
    input  logic [t08_mmio_pkg::DATA_W-1:0]  data_i,
    // touch panel
    input  logic [t08_mmio_pkg::DATA_W-1:0]  touch_xy_i,
    input  logic                             touch_strobe_i,
    // back to memory handler
    output logic [t08_mmio_pkg::DATA_W-1:0]  data_o,
    output logic                             busy_o,
    output logic                             done_o,
    output logic                             touch_done_o,
    // display command stream
    output logic [t08_mmio_pkg::DATA_W-1:0]  spi_word_o,
    output logic                             spi_word_valid_o,
    output logic                             spi_is_param_o
);
    import t08_mmio_pkg::*;

    // touch latch to decoder
    logic [DATA_W-1:0] i2c_xy;
    logic              i2c_done;
    // decoder to spi collector
    logic [DATA_W-1:0] spi_data;
    logic              spi_comm_en;
    logic              spi_param_en;
    logic              spi_busy;
    // wb memory port
    logic [DATA_W-1:0] mem_wdata;
    logic [DATA_W-1:0] mem_rdata;
    logic [DATA_W-1:0] mem_addr;
    logic [SEL_W-1:0]  mem_sel;
    logic              mem_we;
    logic              mem_re;
    logic              mem_busy;

    t08_mmio mmio_i (
        .clk                (clk),
        .nRst               (nRst),
        .read_i             (read_i),
        .write_i            (write_i),
        .wb_read_i          (wb_read_i),
        .wb_write_i         (wb_write_i),
        .address_i          (address_i),
        .mh_data_i          (data_i),
        .i2c_xy_i           (i2c_xy),
        .i2c_done_i         (i2c_done),
        .spi_busy_i         (spi_busy),
        .mem_data_i         (mem_rdata),
        .mem_busy_i         (mem_busy),
        .mh_data_o          (data_o),
        .mmio_busy_o        (busy_o),
        .i2c_done_o         (touch_done_o),
        .mmio_done_o        (done_o),
        .spi_data_o         (spi_data),
        .spi_comm_enable_o  (spi_comm_en),
        .spi_param_enable_o (spi_param_en),
        .mem_data_o         (mem_wdata),
        .mem_address_o      (mem_addr),
        .mem_select_o       (mem_sel),
        .mem_write_o        (mem_we),
        .mem_read_o         (mem_re)
    );

    t08_data_sram sram_i (
        .clk           (clk),
        .nRst          (nRst),
        .mem_read_i    (mem_re),
        .mem_write_i   (mem_we),
        .mem_address_i (mem_addr),
        .mem_data_i    (mem_wdata),
        .mem_select_i  (mem_sel),
        .mem_data_o    (mem_rdata),
        .mem_busy_o    (mem_busy)
    );

    t08_spi_cmd_collector spi_i (
        .clk                (clk),
        .nRst               (nRst),
        .spi_data_i         (spi_data),
        .spi_comm_enable_i  (spi_comm_en),
        .spi_param_enable_i (spi_param_en),
        .spi_busy_o         (spi_busy),
        .spi_word_o         (spi_word_o),
        .spi_word_valid_o   (spi_word_valid_o),
        .spi_is_param_o     (spi_is_param_o)
    );

    t08_touch_latch touch_i (
        .clk            (clk),
        .nRst           (nRst),
        .touch_xy_i     (touch_xy_i),
        .touch_strobe_i (touch_strobe_i),
        .i2c_xy_o       (i2c_xy),
        .i2c_done_o     (i2c_done)
    );

endmodule

//--- tests/t08_mmio_tb.sv
`timescale 1ns/1ns

module t08_mmio_tb;
    import t08_mmio_pkg::*;

    localparam int N_MEM      = 24;    // words written then read back
    localparam int N_FRAMES   = 12;
    localparam int N_TOUCH    = 4;
    localparam int N_DECODE   = 16;
    localparam int N_TXN      = 2 * N_MEM + N_FRAMES + 6 + N_TOUCH + 2 * N_DECODE;
    localparam int TIMEOUT_NS = (N_TXN * 200 + 100) * 8;

    logic              clk = 1'b0;
    logic              nRst;
    logic              read_lvl;
    logic              write_lvl;
    logic              wb_read;
    logic              wb_write;
    logic [DATA_W-1:0] address;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] touch_xy;
    logic              touch_strobe;
    logic [DATA_W-1:0] rdata;
    logic              busy;
    logic              done;
    logic              touch_done;
    logic [DATA_W-1:0] spi_word;
    logic              spi_valid;
    logic              spi_is_param;

    // reference model state
    logic [DATA_W-1:0]     m_mem [MEM_WORDS];
    int                    m_mem_busy;
    logic                  m_rd_pending;
    logic [MEM_ADDR_W-1:0] m_rd_addr;
    logic [DATA_W-1:0]     m_rdata;         // memory read register
    logic                  m_in_frame;
    int                    m_left;          // params still owed
    int                    m_drain;
    logic                  m_valid;
    logic                  m_is_param;
    logic [DATA_W-1:0]     m_word;
    int                    m_settle;
    logic [DATA_W-1:0]     m_xy;
    logic                  m_bq1;
    logic                  m_bq2;
    string                 test_name;

    always #4 clk = ~clk;   // 8 ns period

    t08_mmio_top dut_i (
        .clk              (clk),
        .nRst             (nRst),
        .read_i           (read_lvl),
        .write_i          (write_lvl),
        .wb_read_i        (wb_read),
        .wb_write_i       (wb_write),
        .address_i        (address),
        .data_i           (wdata),
        .touch_xy_i       (touch_xy),
        .touch_strobe_i   (touch_strobe),
        .data_o           (rdata),
        .busy_o           (busy),
        .done_o           (done),
        .touch_done_o     (touch_done),
        .spi_word_o       (spi_word),
        .spi_word_valid_o (spi_valid),
        .spi_is_param_o   (spi_is_param)
    );

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic value_error(input string what, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
        $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
        abort_run();
    endtask

    function automatic logic spi_busy_now();
        return m_in_frame || m_drain != 0;
    endfunction

    function automatic logic exp_busy();
        return spi_busy_now() || m_mem_busy != 0 || m_settle != 0;   // touch not done
    endfunction

    // read path from the address map
    function automatic logic [DATA_W-1:0] exp_data();
        if (!(read_lvl && !write_lvl)) return '0;
        if (address == I2C_ADDR_XY) return (m_settle == 0) ? m_xy : '0;
        if (address < MEM_WORDS) begin
            if (m_mem_busy != 0) return MEM_BUSY_WORD;
            return (m_rdata == MEM_POISON_WORD) ? '0 : m_rdata;
        end
        return '0;
    endfunction

    // model steps on the same edge as the DUT, inputs still hold old values
    always @(posedge clk) begin : model_step
        logic wr_only;
        logic cmd_take;
        logic param_take;
        logic busy_then;
        wr_only    = write_lvl && !read_lvl;
        busy_then  = exp_busy();
        cmd_take   = wr_only && address == SPI_ADDR_CMD && !spi_busy_now();
        param_take = wr_only && address == SPI_ADDR_PARAM && m_in_frame;
        if (!nRst) begin
            m_mem_busy   = 0;
            m_rd_pending = 1'b0;
            m_rdata      = '0;
            m_in_frame   = 1'b0;
            m_left       = 0;
            m_drain      = 0;
            m_valid      = 1'b0;
            m_is_param   = 1'b0;
            m_settle     = 0;
            m_xy         = '0;
            m_bq1        = 1'b0;
            m_bq2        = 1'b0;
        end else begin
            // memory, strobes dropped while busy
            if ((wb_read || wb_write) && m_mem_busy == 0) begin
                if (wb_write) m_mem[address[MEM_ADDR_W-1:0]] = wdata;
                m_mem_busy   = MEM_LATENCY;
                m_rd_pending = wb_read;
                m_rd_addr    = address[MEM_ADDR_W-1:0];
            end else if (m_mem_busy != 0) begin
                m_mem_busy--;
                if (m_mem_busy == 0 && m_rd_pending) begin
                    m_rdata      = m_mem[m_rd_addr];   // word lands as busy ends
                    m_rd_pending = 1'b0;
                end
            end
            // spi frame
            m_valid    = cmd_take || param_take;
            m_is_param = param_take;
            if (m_valid) m_word = wdata;
            if (cmd_take) begin
                m_left = wdata[SPI_COUNT_LSB +: SPI_COUNT_W];
                if (m_left == 0) m_drain = SPI_DRAIN_CYCLES;
                else m_in_frame = 1'b1;
            end else if (param_take) begin
                m_left--;
                if (m_left == 0) begin
                    m_in_frame = 1'b0;
                    m_drain    = SPI_DRAIN_CYCLES;
                end
            end else if (m_drain != 0) begin
                m_drain--;
            end
            // touch
            if (touch_strobe) begin
                m_xy     = touch_xy;
                m_settle = TOUCH_SETTLE_CYCLES;
            end else if (m_settle != 0) begin
                m_settle--;
            end
            m_bq2 = m_bq1;
            m_bq1 = busy_then;
        end
    end

    // compare mid cycle, everything settled
    always @(negedge clk) begin
        if (nRst) begin
            assert (rdata === exp_data()) else value_error("data_o", exp_data(), rdata);
            assert (busy === exp_busy()) else value_error("busy_o", exp_busy(), busy);
            assert (done === (m_bq1 && m_bq2)) else value_error("done_o", m_bq1 && m_bq2, done);
            assert (touch_done === (m_settle == 0))
                else value_error("touch_done_o", m_settle == 0, touch_done);
            assert (spi_valid === m_valid) else value_error("spi_word_valid_o", m_valid, spi_valid);
            if (m_valid) begin
                assert (spi_is_param === m_is_param)
                    else value_error("spi_is_param_o", m_is_param, spi_is_param);
                assert (spi_word === m_word) else value_error("spi_word_o", m_word, spi_word);
            end
        end
    end

    task automatic drive(input logic rd, input logic wr, input logic wbr, input logic wbw,
                         input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] wd);
        @(posedge clk);
        read_lvl  <= rd;
        write_lvl <= wr;
        wb_read   <= wbr;
        wb_write  <= wbw;
        address   <= addr;
        wdata     <= wd;
    endtask

    task automatic idle();
        drive(1'b0, 1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic pulse_touch(input logic [DATA_W-1:0] xy);
        @(posedge clk);
        touch_strobe <= 1'b1;
        touch_xy     <= xy;
        @(posedge clk);
        touch_strobe <= 1'b0;
    endtask

    // returns how many negedges busy_o was seen high
    task automatic wait_idle(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (busy !== 1'b0) begin
            cycles++;
            if (cycles > 200) begin
                $display("busy_o stayed high for over 200 cycles in %s", test_name);
                abort_run();
            end
            @(negedge clk);
        end
    endtask

    function automatic logic [DATA_W-1:0] mapped_addr(input int k);
        case (k % 4)
            0:       return SPI_ADDR_CMD;
            1:       return SPI_ADDR_PARAM;
            2:       return I2C_ADDR_XY;
            default: return $urandom % MEM_WORDS;
        endcase
    endfunction

    initial begin
        logic [DATA_W-1:0] addrs [N_MEM];
        logic [DATA_W-1:0] words [N_MEM];
        logic [DATA_W-1:0] word;
        logic [DATA_W-1:0] exp;
        int                count;
        int                busy_cycles;
        void'($urandom(86));
        nRst         = 1'b0;
        read_lvl     = 1'b0;
        write_lvl    = 1'b0;
        wb_read      = 1'b0;
        wb_write     = 1'b0;
        address      = '0;
        wdata        = '0;
        touch_xy     = '0;
        touch_strobe = 1'b0;
        test_name    = "reset";
        repeat (5) @(posedge clk);
        nRst <= 1'b1;

        test_name = "mem_round_trip";
        for (int i = 0; i < N_MEM; i++) begin
            addrs[i] = i * 85 + $urandom % 85;     // distinct, spread over the window
            words[i] = (i % 5 == 2) ? MEM_POISON_WORD : $urandom;
            drive(1'b0, 1'b1, 1'b0, 1'b1, addrs[i], words[i]);
            idle();
            wait_idle(busy_cycles);
        end
        for (int i = 0; i < N_MEM; i++) begin
            drive(1'b1, 1'b0, 1'b1, 1'b0, addrs[i], '0);
            drive(1'b1, 1'b0, 1'b0, 1'b0, addrs[i], '0);  // hold read level, busy word
            wait_idle(busy_cycles);
            exp = (words[i] == MEM_POISON_WORD) ? '0 : words[i];
            assert (rdata === exp) else value_error("readback", exp, rdata);
            idle();
        end

        test_name = "spi_frames";
        for (int f = 0; f < N_FRAMES; f++) begin
            count = $urandom % 4;
            word  = $urandom;
            word[SPI_COUNT_LSB +: SPI_COUNT_W] = count;
            drive(1'b0, 1'b1, 1'b0, 1'b0, SPI_ADDR_CMD, word);
            for (int p = 0; p < count; p++) begin
                drive(1'b0, 1'b1, 1'b0, 1'b0, SPI_ADDR_PARAM, $urandom);
            end
            idle();
            wait_idle(busy_cycles);
            assert (busy_cycles == SPI_DRAIN_CYCLES)
                else value_error("drain cycles", SPI_DRAIN_CYCLES, busy_cycles);
        end

        test_name = "refused_cmd";
        word = $urandom;
        word[SPI_COUNT_LSB +: SPI_COUNT_W] = 2;
        drive(1'b0, 1'b1, 1'b0, 1'b0, SPI_ADDR_CMD, word);
        drive(1'b0, 1'b1, 1'b0, 1'b0, SPI_ADDR_CMD, $urandom);    // mid frame, dropped
        drive(1'b0, 1'b1, 1'b0, 1'b0, SPI_ADDR_PARAM, $urandom);
        drive(1'b0, 1'b1, 1'b0, 1'b0, SPI_ADDR_PARAM, $urandom);
        idle();
        wait_idle(busy_cycles);
        drive(1'b0, 1'b1, 1'b0, 1'b0, SPI_ADDR_PARAM, $urandom);  // no frame open
        idle();
        @(negedge clk);
        assert (spi_valid === 1'b0) else value_error("stray param valid", 1'b0, spi_valid);

        test_name = "touch";
        for (int t = 0; t < N_TOUCH; t++) begin
            word = $urandom;
            drive(1'b1, 1'b0, 1'b0, 1'b0, I2C_ADDR_XY, '0);   // read stays up through settle
            pulse_touch(word);
            wait_idle(busy_cycles);
            assert (busy_cycles == TOUCH_SETTLE_CYCLES)
                else value_error("settle cycles", TOUCH_SETTLE_CYCLES, busy_cycles);
            assert (rdata === word) else value_error("touch xy", word, rdata);
            idle();
        end

        test_name = "decode_corners";
        for (int d = 0; d < N_DECODE; d++) begin
            word = 32'd4096 + $urandom % 100000;      // above memory, below every mmio port
            drive(d % 2 == 0, d % 2 == 1, 1'b0, 1'b0, word, $urandom);
            drive(1'b1, 1'b1, 1'b0, 1'b0, mapped_addr(d), $urandom);
        end
        idle();
        wait_idle(busy_cycles);

        $display("Test completed successfully");
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns without the run finishing", TIMEOUT_NS);
        abort_run();
    end

endmodule

//--- list.f
design/t08_mmio_pkg.sv
design/t08_mmio.sv
design/t08_data_sram.sv
design/t08_spi_cmd_collector.sv
design/t08_touch_latch.sv
design/t08_mmio_top.sv
tests/t08_mmio_tb.sv

//--- Bender.yml
package:
  name: t08_mmio

sources:
  - design/t08_mmio_pkg.sv
  - design/t08_mmio.sv
  - design/t08_data_sram.sv
  - design/t08_spi_cmd_collector.sv
  - design/t08_touch_latch.sv
  - design/t08_mmio_top.sv
  - target: test
    files:
      - tests/t08_mmio_tb.sv
